//--- list.f
+incdir+src
src/memmap_pkg.sv
src/memmap_region_table.sv
src/memmap_region_decode.sv
src/memmap_demux.sv
src/memmap_bank.sv
src/memmap_subsystem.sv
bench/memmap_asserts.sv
bench/memmap_tb.sv

//--- bench/memmap_tb.sv
/*
 * Testbench for the memory-mapped target subsystem.
 * Clock and reset, a stimulus table with expected responses applied in
 * a loop, random r_ready stalls, a cycle watchdog and the final report.
 */

`timescale 1ns/1ns

module memmap_tb;

  import memmap_pkg::*;

  typedef enum logic [1:0] {
    K_ACCESS,
    K_CONFIG,
    K_CLEAR
  } kind_e;

  // One row of the stimulus table.
  typedef struct packed {
    kind_e       kind;
    region_idx_t cfg_idx;
    logic        cfg_sel_end;
    addr_t       cfg_addr;
    core_req_t   req;
    data_t       exp_data;
    logic        exp_err;
  } entry_t;

  localparam int HS_LIMIT = 16;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        clear_i;
  logic        cfg_we_i;
  region_idx_t cfg_idx_i;
  logic        cfg_sel_end_i;
  addr_t       cfg_addr_i;
  logic        req_i;
  logic        gnt_o;
  core_req_t   core_req_i;
  logic        r_valid_o;
  logic        r_ready_i;
  core_rsp_t   core_rsp_o;

  entry_t stim_q[$];
  integer seed;
  int     mismatch_cnt = 0;
  int     proto_cnt = 0;
  int     limit = 0;
  int     cycles = 0;

  memmap_subsystem UUT (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_idx_i     (cfg_idx_i),
    .cfg_sel_end_i (cfg_sel_end_i),
    .cfg_addr_i    (cfg_addr_i),
    .req_i         (req_i),
    .gnt_o         (gnt_o),
    .core_req_i    (core_req_i),
    .r_valid_o     (r_valid_o),
    .r_ready_i     (r_ready_i),
    .core_rsp_o    (core_rsp_o)
  );

  bind memmap_demux memmap_asserts u_asserts (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .clear_i    (clear_i),
    .gnt_i      (gnt_o),
    .r_valid_i  (r_valid_o),
    .r_ready_i  (r_ready_i),
    .rsp_i      (core_rsp_o),
    .bank_req_i (bank_req_o),
    .state_i    (state_q)
  );

  always #2 clk_i = ~clk_i;

  // ==================================================
  // Table builders
  // ==================================================

  function automatic void write_word(input addr_t add, input data_t data, input be_t be,
                                     input data_t exp_data);
    entry_t e;
    e = '0;
    e.kind = K_ACCESS;
    e.req.wen = 1'b0;
    e.req.add = add;
    e.req.data = data;
    e.req.be = be;
    e.exp_data = exp_data;
    stim_q.push_back(e);
  endfunction

  function automatic void read_word(input addr_t add, input data_t exp_data);
    entry_t e;
    e = '0;
    e.kind = K_ACCESS;
    e.req.wen = 1'b1;
    e.req.add = add;
    e.req.be = 4'hF;
    e.exp_data = exp_data;
    stim_q.push_back(e);
  endfunction

  // Unmapped addresses answer with an error and zero data.
  function automatic void unmapped_access(input logic wen, input addr_t add, input data_t data);
    entry_t e;
    e = '0;
    e.kind = K_ACCESS;
    e.req.wen = wen;
    e.req.add = add;
    e.req.data = data;
    e.req.be = 4'hF;
    e.exp_err = 1'b1;
    stim_q.push_back(e);
  endfunction

  function automatic void program_region(input region_idx_t idx, input logic sel_end,
                                         input addr_t addr);
    entry_t e;
    e = '0;
    e.kind = K_CONFIG;
    e.cfg_idx = idx;
    e.cfg_sel_end = sel_end;
    e.cfg_addr = addr;
    stim_q.push_back(e);
  endfunction

  function automatic void clear_map();
    entry_t e;
    e = '0;
    e.kind = K_CLEAR;
    stim_q.push_back(e);
  endfunction

  task automatic build_table();
    // Every default region, same offset in two regions.
    write_word(32'h000, 32'h0000_A000, 4'hF, 32'h0000_A000);
    write_word(32'h104, 32'h1111_B104, 4'hF, 32'h1111_B104);
    write_word(32'h208, 32'h2222_C208, 4'hF, 32'h2222_C208);
    write_word(32'h3FC, 32'h3333_D3FC, 4'hF, 32'h3333_D3FC);
    write_word(32'h010, 32'h0A0A_0A0A, 4'hF, 32'h0A0A_0A0A);
    write_word(32'h110, 32'h1B1B_1B1B, 4'hF, 32'h1B1B_1B1B);
    read_word(32'h000, 32'h0000_A000);
    read_word(32'h104, 32'h1111_B104);
    read_word(32'h208, 32'h2222_C208);
    read_word(32'h3FC, 32'h3333_D3FC);
    read_word(32'h010, 32'h0A0A_0A0A);
    read_word(32'h110, 32'h1B1B_1B1B);
    // Partial byte enables merge into the old word.
    write_word(32'h204, 32'hA5A5_0001, 4'hF, 32'hA5A5_0001);
    write_word(32'h204, 32'h1122_3344, 4'b0101, 32'hA522_0044);
    write_word(32'h3FC, 32'hEE00_0000, 4'b1000, 32'hEE33_D3FC);
    read_word(32'h204, 32'hA522_0044);
    read_word(32'h3FC, 32'hEE33_D3FC);
    // 0x400 would alias word 0 of bank 0 if it leaked through.
    unmapped_access(1'b0, 32'h400, 32'hDEAD_BEEF);
    unmapped_access(1'b1, 32'hFFFF_0000, '0);
    read_word(32'h000, 32'h0000_A000);
    // Move region 1 to 0x1000..0x10FF.
    program_region(2'd1, 1'b0, 32'h1000);
    program_region(2'd1, 1'b1, 32'h1100);
    read_word(32'h1010, 32'h1B1B_1B1B);
    read_word(32'h1004, 32'h1111_B104);
    unmapped_access(1'b1, 32'h110, '0);
    write_word(32'h1020, 32'h1234_5678, 4'hF, 32'h1234_5678);
    // Clear restores the default map, memory is kept.
    clear_map();
    read_word(32'h110, 32'h1B1B_1B1B);
    read_word(32'h120, 32'h1234_5678);
    unmapped_access(1'b1, 32'h1010, '0);
    read_word(32'h000, 32'h0000_A000);
    read_word(32'h204, 32'hA522_0044);
  endtask

  // ==================================================
  // Stimulus and checks
  // ==================================================

  // Waits for the response of a granted access. With hold_req the same
  // access stays requested, and it may be granted again only in the
  // cycle that accepts the pending response.
  task automatic collect_response(input entry_t e, input int idx, input logic hold_req,
                                  output logic regrant);
    core_rsp_t rsp;
    logic      seen;
    int        n;
    rsp = '0;
    seen = 1'b0;
    regrant = 1'b0;
    n = 0;
    req_i = hold_req;
    core_req_i = hold_req ? e.req : '0;
    while (!seen && n < HS_LIMIT) begin
      r_ready_i = (($random(seed) & 3) != 0);
      #1;
      // r_valid is due in the first cycle after the grant
      if (n == 0) begin
        assert (r_valid_o === 1'b1) else begin
          mismatch_cnt++;
          $display("MISMATCH at %0t: entry %0d r_valid missing after grant", $time, idx);
        end
      end
      if (r_valid_o === 1'b1 && r_ready_i) begin
        seen = 1'b1;
        rsp = core_rsp_o;
        regrant = hold_req && (gnt_o === 1'b1);
        if (hold_req) begin
          assert (gnt_o === 1'b1) else begin
            proto_cnt++;
            $display("Entry %0d: the repeated request was not granted %s", idx,
                     "when the response was accepted");
          end
        end
      end else begin
        assert (gnt_o !== 1'b1) else begin
          proto_cnt++;
          $display("Entry %0d: a request was granted while a response was pending", idx);
        end
      end
      @(negedge clk_i);
      n++;
    end
    req_i = 1'b0;
    core_req_i = '0;
    r_ready_i = 1'b0;
    if (!seen) begin
      proto_cnt++;
      $display("Entry %0d: no response came back for address %h", idx, e.req.add);
    end else begin
      assert (rsp.r_data === e.exp_data && rsp.r_err === e.exp_err) else begin
        mismatch_cnt++;
        $display("MISMATCH at %0t: entry %0d add %h got %h err %b, expected %h err %b",
                 $time, idx, e.req.add, rsp.r_data, rsp.r_err, e.exp_data, e.exp_err);
      end
    end
  endtask

  // Called on a falling edge; returns on a falling edge.
  task automatic run_access(input entry_t e, input int idx);
    logic seen;
    logic regrant;
    int   n;
    seen = 1'b0;
    regrant = 1'b0;
    n = 0;
    req_i = 1'b1;
    core_req_i = e.req;
    while (!seen && n < HS_LIMIT) begin
      #1;
      seen = gnt_o;
      @(negedge clk_i);
      n++;
    end
    if (!seen) begin
      req_i = 1'b0;
      core_req_i = '0;
      proto_cnt++;
      $display("Entry %0d: request to address %h was never granted", idx, e.req.add);
      return;
    end
    // The access is issued a second time back to back.
    // Reads and writes both repeat to the same expected response.
    collect_response(e, idx, 1'b1, regrant);
    if (regrant) begin
      collect_response(e, idx, 1'b0, regrant);
    end
  endtask

  task automatic apply_entry(input entry_t e, input int idx);
    case (e.kind)
      K_CONFIG: begin
        cfg_we_i = 1'b1;
        cfg_idx_i = e.cfg_idx;
        cfg_sel_end_i = e.cfg_sel_end;
        cfg_addr_i = e.cfg_addr;
        @(negedge clk_i);
        cfg_we_i = 1'b0;
      end
      K_CLEAR: begin
        clear_i = 1'b1;
        @(negedge clk_i);
        clear_i = 1'b0;
      end
      default: run_access(e, idx);
    endcase
  endtask

  initial begin
    seed = 85175;
    rst_ni = 1'b0;
    clear_i = 1'b0;
    cfg_we_i = 1'b0;
    cfg_idx_i = '0;
    cfg_sel_end_i = 1'b0;
    cfg_addr_i = '0;
    req_i = 1'b0;
    core_req_i = '0;
    r_ready_i = 1'b0;
    build_table();
    limit = stim_q.size() * 20;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    foreach (stim_q[i]) begin
      apply_entry(stim_q[i], i);
    end
    $display("Errors: %0d mismatches, %0d handshake failures, %0d assertion failures",
             mismatch_cnt, proto_cnt, UUT.u_demux.u_asserts.fail_cnt);
    if (mismatch_cnt == 0 && proto_cnt == 0 && UUT.u_demux.u_asserts.fail_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  // Watchdog over the whole run.
  initial begin
    wait (limit != 0);
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("Timeout: the run did not finish within %0d cycles", limit);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

//--- bench/memmap_asserts.sv
/*
 * Protocol assertions for the demux controller, attached with bind.
 * One-hot bank requests, stable responses under back-pressure,
 * no grant while a response waits, no response without a grant.
 */

`timescale 1ns/1ns
`include "memmap_defs.svh"

module memmap_asserts (
  input logic                         clk_i,
  input logic                         rst_ni,
  input logic                         clear_i,
  input logic                         gnt_i,
  input logic                         r_valid_i,
  input logic                         r_ready_i,
  input memmap_pkg::core_rsp_t        rsp_i,
  input logic [`MEMMAP_NB_REGION-1:0] bank_req_i,
  input memmap_pkg::demux_state_e     state_i
);

  import memmap_pkg::*;

  int   fail_cnt = 0;
  logic owed_q;

  // Set by a grant, cleared when its response is accepted.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      owed_q <= 1'b0;
    end else if (clear_i) begin
      owed_q <= 1'b0;
    end else if (gnt_i) begin
      owed_q <= 1'b1;
    end else if (r_valid_i && r_ready_i) begin
      owed_q <= 1'b0;
    end
  end

  // ==================================================
  // Handshake properties
  // ==================================================

  assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(bank_req_i))
    else begin
      fail_cnt++;
      $error("more than one bank request high");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    r_valid_i && !r_ready_i |=> r_valid_i && $stable(rsp_i))
    else begin
      fail_cnt++;
      $error("response changed while r_ready was low");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == RESPONSE) && !(r_valid_i && r_ready_i) |-> !gnt_i)
    else begin
      fail_cnt++;
      $error("grant given while a response was still pending");
    end

  assert property (@(posedge clk_i) disable iff (!rst_ni) r_valid_i |-> owed_q)
    else begin
      fail_cnt++;
      $error("r_valid without an earlier grant");
    end

endmodule

//--- src/memmap_subsystem.sv
/*
 * Top level of the memory-mapped target subsystem.
 * Connects the region table, the decoder, the demux controller
 * and one SRAM bank per region.
 */

`timescale 1ns/1ns
`include "memmap_defs.svh"

module memmap_subsystem (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  // Region table config port.
  input  logic                    cfg_we_i,
  input  memmap_pkg::region_idx_t cfg_idx_i,
  input  logic                    cfg_sel_end_i,
  input  memmap_pkg::addr_t       cfg_addr_i,
  // Core port.
  input  logic                    req_i,
  output logic                    gnt_o,
  input  memmap_pkg::core_req_t   core_req_i,
  output logic                    r_valid_o,
  input  logic                    r_ready_i,
  output memmap_pkg::core_rsp_t   core_rsp_o
);

  import memmap_pkg::*;

  addr_t     [`MEMMAP_NB_REGION-1:0] region_start;
  addr_t     [`MEMMAP_NB_REGION-1:0] region_end;
  addr_t     [`MEMMAP_NB_REGION-1:0] region_offset;
  logic                              hit;
  region_idx_t                       region;
  logic      [`MEMMAP_NB_REGION-1:0] bank_req;
  logic      [`MEMMAP_NB_REGION-1:0] bank_gnt;
  core_req_t [`MEMMAP_NB_REGION-1:0] bank_payload;
  logic      [`MEMMAP_NB_REGION-1:0] bank_r_valid;
  core_rsp_t [`MEMMAP_NB_REGION-1:0] bank_rsp;
  logic      [`MEMMAP_NB_REGION-1:0] bank_r_ready;

  memmap_region_table u_table (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear_i),
    .cfg_we_i      (cfg_we_i),
    .cfg_idx_i     (cfg_idx_i),
    .cfg_sel_end_i (cfg_sel_end_i),
    .cfg_addr_i    (cfg_addr_i),
    .start_o       (region_start),
    .end_o         (region_end)
  );

  memmap_region_decode u_decode (
    .add_i    (core_req_i.add),
    .start_i  (region_start),
    .end_i    (region_end),
    .hit_o    (hit),
    .region_o (region),
    .offset_o (region_offset)
  );

  memmap_demux u_demux (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .clear_i            (clear_i),
    .req_i              (req_i),
    .gnt_o              (gnt_o),
    .core_req_i         (core_req_i),
    .r_valid_o          (r_valid_o),
    .r_ready_i          (r_ready_i),
    .core_rsp_o         (core_rsp_o),
    .hit_i              (hit),
    .region_i           (region),
    .offset_i           (region_offset),
    .bank_req_o         (bank_req),
    .bank_gnt_i         (bank_gnt),
    .bank_req_payload_o (bank_payload),
    .bank_r_valid_i     (bank_r_valid),
    .bank_rsp_i         (bank_rsp),
    .bank_r_ready_o     (bank_r_ready)
  );

  // One bank per region.
  for (genvar i = 0; i < `MEMMAP_NB_REGION; i++) begin : g_bank
    memmap_bank u_bank (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .clear_i       (clear_i),
      .req_i         (bank_req[i]),
      .gnt_o         (bank_gnt[i]),
      .req_payload_i (bank_payload[i]),
      .r_valid_o     (bank_r_valid[i]),
      .r_ready_i     (bank_r_ready[i]),
      .rsp_o         (bank_rsp[i])
    );
  end

endmodule

//--- src/memmap_bank.sv
/*
 * Byte-enabled SRAM bank with a req/gnt request port.
 * One cycle from grant to r_valid, response held until r_ready.
 * Reads return the stored word, writes return the updated word.
 */

`timescale 1ns/1ns
`include "memmap_defs.svh"

module memmap_bank (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  req_i,
  output logic                  gnt_o,
  input  memmap_pkg::core_req_t req_payload_i,
  output logic                  r_valid_o,
  input  logic                  r_ready_i,
  output memmap_pkg::core_rsp_t rsp_o
);

  import memmap_pkg::*;

  localparam int unsigned WORD_AW = $clog2(`MEMMAP_BANK_WORDS);
  localparam int unsigned BE_W    = $bits(be_t);

  data_t              mem [`MEMMAP_BANK_WORDS];
  logic [WORD_AW-1:0] word_idx;
  data_t              word_next;
  data_t              rdata_q;
  logic               pending_q;
  logic               transfer;

  // Byte address to word index, wraps at the bank depth.
  assign word_idx = req_payload_i.add[2 +: WORD_AW];

  // Free when empty, or when the held response leaves this cycle.
  assign gnt_o    = !pending_q || r_ready_i;
  assign transfer = req_i && gnt_o && !clear_i;

  // Stored word with the enabled bytes replaced on a write.
  always_comb begin
    word_next = mem[word_idx];
    for (int unsigned b = 0; b < BE_W; b++) begin
      if (!req_payload_i.wen && req_payload_i.be[b]) begin
        word_next[8*b +: 8] = req_payload_i.data[8*b +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (transfer) begin
      rdata_q <= word_next;
      if (!req_payload_i.wen) begin
        mem[word_idx] <= word_next;
      end
    end
  end

  // Pending flag, a new grant takes priority over the accept.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
    end else if (clear_i) begin
      pending_q <= 1'b0;
    end else if (transfer) begin
      pending_q <= 1'b1;
    end else if (r_ready_i) begin
      pending_q <= 1'b0;
    end
  end

  assign r_valid_o    = pending_q;
  assign rsp_o.r_data = rdata_q;
  assign rsp_o.r_err  = 1'b0;

endmodule

//--- src/memmap_demux.sv
/*
 * Request demultiplexer and response controller.
 * Two-state FSM that steers requests and grants to the addressed bank,
 * remembers the region in flight and returns the bank response or an
 * error response for unmapped addresses.
 */

`timescale 1ns/1ns
`include "memmap_defs.svh"

module memmap_demux (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  input  logic                                          clear_i,
  // Core port.
  input  logic                                          req_i,
  output logic                                          gnt_o,
  input  memmap_pkg::core_req_t                         core_req_i,
  output logic                                          r_valid_o,
  input  logic                                          r_ready_i,
  output memmap_pkg::core_rsp_t                         core_rsp_o,
  // Decoder results.
  input  logic                                          hit_i,
  input  memmap_pkg::region_idx_t                       region_i,
  input  memmap_pkg::addr_t [`MEMMAP_NB_REGION-1:0]     offset_i,
  // Bank ports.
  output logic [`MEMMAP_NB_REGION-1:0]                  bank_req_o,
  input  logic [`MEMMAP_NB_REGION-1:0]                  bank_gnt_i,
  output memmap_pkg::core_req_t [`MEMMAP_NB_REGION-1:0] bank_req_payload_o,
  input  logic [`MEMMAP_NB_REGION-1:0]                  bank_r_valid_i,
  input  memmap_pkg::core_rsp_t [`MEMMAP_NB_REGION-1:0] bank_rsp_i,
  output logic [`MEMMAP_NB_REGION-1:0]                  bank_r_ready_o
);

  import memmap_pkg::*;

  demux_state_e state_q, state_d;
  region_idx_t  region_q;
  logic         hit_q;
  logic         accept;
  logic         can_issue;
  logic         target_gnt;

  // ================================================
  // Grant and bank request steering
  // ================================================

  assign accept     = r_valid_o && r_ready_i;
  // A new request may go out when idle or when the pending response leaves.
  assign can_issue  = (state_q == IDLE) || accept;
  // Unmapped addresses need no bank, the error is made here.
  assign target_gnt = hit_i ? bank_gnt_i[region_i] : 1'b1;
  assign gnt_o      = req_i && can_issue && target_gnt;

  always_comb begin
    bank_req_o = '0;
    bank_req_o[region_i] = req_i && hit_i && can_issue;
  end

  // Every bank sees the request with its own region-relative address.
  always_comb begin
    for (int unsigned i = 0; i < `MEMMAP_NB_REGION; i++) begin
      bank_req_payload_o[i]     = core_req_i;
      bank_req_payload_o[i].add = offset_i[i];
    end
  end

  // ================================================
  // FSM and in-flight region
  // ================================================

  always_comb begin
    state_d = state_q;
    if (gnt_o) begin
      state_d = RESPONSE;
    end else if (accept) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= IDLE;
      region_q <= '0;
      hit_q    <= 1'b0;
    end else if (clear_i) begin
      state_q  <= IDLE;
      region_q <= '0;
      hit_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (gnt_o) begin
        region_q <= region_i;
        hit_q    <= hit_i;
      end
    end
  end

  // ================================================
  // Response path
  // ================================================

  always_comb begin
    r_valid_o  = 1'b0;
    core_rsp_o = '0;
    if (state_q == RESPONSE) begin
      if (hit_q) begin
        r_valid_o  = bank_r_valid_i[region_q];
        core_rsp_o = bank_rsp_i[region_q];
      end else begin
        // Miss: error with zero data.
        r_valid_o        = 1'b1;
        core_rsp_o.r_err = 1'b1;
      end
    end
  end

  always_comb begin
    bank_r_ready_o = '0;
    bank_r_ready_o[region_q] = (state_q == RESPONSE) && hit_q && r_ready_i;
  end

endmodule

//--- src/memmap_region_decode.sv
/*
 * Combinational address decoder.
 * Matches an address against every region of the table, picks the
 * highest matching index and forms the region-relative offsets.
 */

`timescale 1ns/1ns
`include "memmap_defs.svh"

module memmap_region_decode (
  input  memmap_pkg::addr_t                           add_i,
  input  memmap_pkg::addr_t [`MEMMAP_NB_REGION-1:0]   start_i,
  input  memmap_pkg::addr_t [`MEMMAP_NB_REGION-1:0]   end_i,
  output logic                                        hit_o,
  output memmap_pkg::region_idx_t                     region_o,
  output memmap_pkg::addr_t [`MEMMAP_NB_REGION-1:0]   offset_o
);

  import memmap_pkg::*;

  logic [`MEMMAP_NB_REGION-1:0] match;

  // ================================================
  // Region match
  // ================================================

  // A region hits when start <= add < end.
  always_comb begin
    for (int unsigned i = 0; i < `MEMMAP_NB_REGION; i++) begin
      match[i] = (add_i >= start_i[i]) && (add_i < end_i[i]);
    end
  end

  // Later matches overwrite earlier ones, so the highest index wins.
  always_comb begin
    region_o = '0;
    for (int unsigned i = 0; i < `MEMMAP_NB_REGION; i++) begin
      if (match[i]) begin
        region_o = region_idx_t'(i);
      end
    end
  end

  assign hit_o = |match;

  // ================================================
  // Relative offsets
  // ================================================

  // One offset per region, the demux forwards each to its own bank.
  always_comb begin
    for (int unsigned i = 0; i < `MEMMAP_NB_REGION; i++) begin
      offset_o[i] = add_i - start_i[i];
    end
  end

endmodule

//--- src/memmap_region_table.sv
/*
 * Programmable region table.
 * Holds a start and an end address per region, loads the default
 * spans on reset or clear and applies one config write per cycle.
 */

`timescale 1ns/1ns
`include "memmap_defs.svh"

module memmap_region_table (
  input  logic                                        clk_i,
  input  logic                                        rst_ni,
  input  logic                                        clear_i,
  input  logic                                        cfg_we_i,
  input  memmap_pkg::region_idx_t                     cfg_idx_i,
  input  logic                                        cfg_sel_end_i,
  input  memmap_pkg::addr_t                           cfg_addr_i,
  output memmap_pkg::addr_t [`MEMMAP_NB_REGION-1:0]   start_o,
  output memmap_pkg::addr_t [`MEMMAP_NB_REGION-1:0]   end_o
);

  import memmap_pkg::*;

  addr_t [`MEMMAP_NB_REGION-1:0] start_q;
  addr_t [`MEMMAP_NB_REGION-1:0] end_q;

  // Base address of region idx in the default map.
  function automatic addr_t region_base(input int unsigned idx);
    return addr_t'(idx * `MEMMAP_REGION_SPAN);
  endfunction

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < `MEMMAP_NB_REGION; i++) begin
        start_q[i] <= region_base(i);
        end_q[i]   <= region_base(i + 1);
      end
    end else if (clear_i) begin
      for (int unsigned i = 0; i < `MEMMAP_NB_REGION; i++) begin
        start_q[i] <= region_base(i);
        end_q[i]   <= region_base(i + 1);
      end
    end else if (cfg_we_i) begin
      // One entry per write, start or end picked by cfg_sel_end_i.
      if (cfg_sel_end_i) begin
        end_q[cfg_idx_i] <= cfg_addr_i;
      end else begin
        start_q[cfg_idx_i] <= cfg_addr_i;
      end
    end
  end

  assign start_o = start_q;
  assign end_o   = end_q;

endmodule

//--- src/memmap_pkg.sv
/*
 * Shared types of the memory-mapped target subsystem.
 * Address, data, byte-enable and region index vectors,
 * the core request and response structs and the demux state enum.
 */

`include "memmap_defs.svh"

package memmap_pkg;

  // ================================================
  // Plain vector types
  // ================================================

  typedef logic [`MEMMAP_AW-1:0]                addr_t;
  typedef logic [`MEMMAP_DW-1:0]                data_t;
  typedef logic [`MEMMAP_DW/8-1:0]              be_t;
  typedef logic [$clog2(`MEMMAP_NB_REGION)-1:0] region_idx_t;

  // ================================================
  // Core port payloads
  // ================================================

  // Request payload. wen is active low, so 0 means write.
  typedef struct packed {
    addr_t add;
    logic  wen;
    data_t data;
    be_t   be;
  } core_req_t;

  // Response payload returned with r_valid.
  typedef struct packed {
    data_t r_data;
    logic  r_err;
  } core_rsp_t;

  // Demux controller states.
  typedef enum logic {
    IDLE,
    RESPONSE
  } demux_state_e;

endpackage

//--- src/memmap_defs.svh
/*
 * Width, region count and bank size macros for the memory-mapped
 * target subsystem. Definitions only, guarded against double inclusion.
 */

`ifndef MEMMAP_DEFS_SVH
`define MEMMAP_DEFS_SVH

// Address and data widths in bits.
`define MEMMAP_AW 32
`define MEMMAP_DW 32

// Number of address regions, one SRAM bank per region.
`define MEMMAP_NB_REGION 4

// Default region size in bytes.
// Region i covers [i*SPAN, (i+1)*SPAN) after reset.
`define MEMMAP_REGION_SPAN 'h100

// Words per SRAM bank.
`define MEMMAP_BANK_WORDS 64

`endif
